// ==== list.f ====
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_hazard_unit.sv
hdl/rv_branch_unit.sv
hdl/rv_pipeline.sv
verification/rv_clock_gen.sv
verification/rv_pipeline_tb.sv

// ==== Makefile ====
# Verilator build for the pipelined RV32I core.

VERILATOR ?= verilator
TOP       ?= rv_pipeline_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= NO ERRORS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up as a line of its own.
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/rv_pipeline_tb.sv ====
`timescale 1ns/1ps

module rv_pipeline_tb;

    localparam int ADDR_SIZE = 10;
    localparam int MEM_WORDS = 1 << ADDR_SIZE;
    localparam int PROG_LEN  = 160;
    localparam int SEED      = 5;
    localparam int TIMEOUT   = 5000;
    localparam int DRAIN     = 20;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [ADDR_SIZE-1:0] addr;
        logic [31:0]          data;
    } store_t;

    logic                 CLK;
    logic                 RESET_N;
    logic [ADDR_SIZE-1:0] iaddr;
    logic [ADDR_SIZE-1:0] daddr;
    logic [31:0]          idata;
    logic [31:0]          ddata_r;
    logic [31:0]          ddata_w;
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write_enable;
    logic [4:0]           write_register;
    logic [31:0]          reg_write_data;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];

    reg_write_t exp_writes [$];
    store_t     exp_stores [$];
    int         wr_count = 0;
    int         st_count = 0;
    int         wr_errors = 0;
    int         st_errors = 0;
    int         other_errors = 0;
    int         cycles_out_of_reset = 0;

    rv_clock_gen clock_gen (
        .CLK     (CLK),
        .RESET_N (RESET_N)
    );

    rv_pipeline #(
        .ADDR_SIZE (ADDR_SIZE)
    ) UUT (
        .CLK              (CLK),
        .RESET_N          (RESET_N),
        .iaddr            (iaddr),
        .idata            (idata),
        .daddr            (daddr),
        .ddata_r          (ddata_r),
        .ddata_w          (ddata_w),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .reg_write_enable (reg_write_enable),
        .write_register   (write_register),
        .reg_write_data   (reg_write_data)
    );

    // ==========================================================================
    // memory models
    // ==========================================================================

    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    function automatic logic [31:0] init_word(input int addr);
        return 32'hC3A5_0000 ^ (32'(addr) * 32'h0001_0007);
    endfunction

    // the data memory takes its start contents while reset is held.
    always @(posedge CLK) begin
        if (!RESET_N) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                dmem[a] <= init_word(a);
            end
        end else if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    // ==========================================================================
    // program generator
    // ==========================================================================

    function automatic logic [31:0] r_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, rv_pkg::OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd,
                                           input rv_pkg::opcode_e opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], rv_pkg::BRANCH};
    endfunction

    // a small register set keeps dependencies at distance one to three frequent.
    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(7, 0));
    endfunction

    function automatic void build_program();
        int          n;
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] off;
        logic [2:0]  f3;
        for (int a = 0; a < MEM_WORDS; a++) begin
            imem[a] = i_word(12'(a), 5'd0, 3'b000, 5'd0, rv_pkg::OP_IMM);
        end
        for (n = 0; n < 7; n++) begin
            imem[n] = i_word(12'($urandom), 5'd0, 3'b000, 5'(n + 1), rv_pkg::OP_IMM);
        end
        while (n < PROG_LEN - 4) begin
            kind = $urandom_range(11, 0);
            rd   = pick_reg();
            rs1  = pick_reg();
            rs2  = pick_reg();
            off  = 12'($urandom_range(63, 0) * 4);
            f3   = {2'b00, 1'($urandom)};
            case (kind)
                0:       imem[n] = r_word(7'h00, rs2, rs1, 3'b000, rd);
                1:       imem[n] = r_word(7'h20, rs2, rs1, 3'b000, rd);
                2:       imem[n] = r_word(7'h00, rs2, rs1, 3'b111, rd);
                3:       imem[n] = r_word(7'h00, rs2, rs1, 3'b110, rd);
                4:       imem[n] = r_word(7'h00, rs2, rs1, 3'b010, rd);
                5, 6:    imem[n] = i_word(12'($urandom), rs1, 3'b000, rd, rv_pkg::OP_IMM);
                7:       imem[n] = i_word(off, rs1, 3'b010, rd, rv_pkg::LOAD);
                8:       imem[n] = s_word(off, rs2, rs1);
                9: begin
                    // store, reload of the same word, then an immediate use of it.
                    imem[n] = s_word(off, rs2, rs1);
                    n++;
                    imem[n] = i_word(off, rs1, 3'b010, rd, rv_pkg::LOAD);
                    n++;
                    imem[n] = r_word(7'h00, pick_reg(), rd, 3'b000, pick_reg());
                end
                10:      imem[n] = b_word(13'($urandom_range(4, 1) * 4), rs2, rs1, f3);
                default: imem[n] = b_word(13'($urandom_range(4, 1) * 4), rs1, rs1, f3);
            endcase
            n++;
        end
        imem[PROG_LEN - 1] = b_word(13'd0, 5'd0, 5'd0, 3'b000);
    endfunction

    // ==========================================================================
    // reference model
    // ==========================================================================

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    // runs until the closing self-loop; every branch is forward, so it always gets there.
    function automatic void run_reference();
        logic [31:0] x [32];
        logic [31:0] mem [MEM_WORDS];
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] res;
        logic [31:0] ea;
        logic [4:0]  rd;
        logic        wr;
        int          pc;
        int          steps;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = init_word(i);
        end
        pc    = 0;
        steps = 0;
        while (pc != PROG_LEN - 1 && steps < PROG_LEN) begin
            inst  = imem[pc];
            rd    = inst[11:7];
            a     = x[inst[19:15]];
            b     = x[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            wr    = 1'b0;
            res   = '0;
            pc    = pc + 1;
            case (rv_pkg::opcode_e'(inst[6:0]))
                rv_pkg::OP: begin
                    res = alu_model(inst[14:12], inst[30], a, b);
                    wr  = 1'b1;
                end
                rv_pkg::OP_IMM: begin
                    res = alu_model(inst[14:12], 1'b0, a, imm_i);
                    wr  = 1'b1;
                end
                rv_pkg::LOAD: begin
                    ea  = a + imm_i;
                    res = mem[ea[ADDR_SIZE+1:2]];
                    wr  = 1'b1;
                end
                rv_pkg::STORE: begin
                    ea = a + imm_s;
                    mem[ea[ADDR_SIZE+1:2]] = b;
                    exp_stores.push_back({ea[ADDR_SIZE+1:2], b});
                end
                rv_pkg::BRANCH: begin
                    if (inst[12] ? a != b : a == b) begin
                        pc = pc - 1 + int'($signed(imm_b) >>> 2);
                    end
                end
                default: ;
            endcase
            if (wr && rd != 5'd0) begin
                x[rd] = res;
                exp_writes.push_back({rd, res});
            end
            steps++;
        end
    endfunction

    // ==========================================================================
    // checker
    // ==========================================================================

    always @(negedge CLK) begin
        reg_write_t exp_w;
        store_t     exp_s;
        if (!RESET_N || cycles_out_of_reset == 0) begin
            assert (!mem_write && !mem_read && !reg_write_enable) else begin
                $display("a strobe was high during reset or in the first cycle after it");
                other_errors++;
            end
        end
        cycles_out_of_reset = RESET_N ? cycles_out_of_reset + 1 : 0;
        if (RESET_N && reg_write_enable) begin
            assert (write_register != 5'd0) else begin
                $display("a write to x0 appeared on the observation port");
                other_errors++;
            end
            assert (wr_count < exp_writes.size()) else begin
                $display("a register write came after the last expected one");
                other_errors++;
            end
            if (wr_count < exp_writes.size()) begin
                exp_w = exp_writes[wr_count];
                assert (write_register == exp_w.rd && reg_write_data == exp_w.data) else begin
                    $display("error reg_write[%0d]: expected x%0d = %h, actual x%0d = %h",
                             wr_count, exp_w.rd, exp_w.data, write_register, reg_write_data);
                    wr_errors++;
                end
            end
            wr_count++;
        end
        if (RESET_N && mem_write) begin
            assert (st_count < exp_stores.size()) else begin
                $display("a store came after the last expected one");
                other_errors++;
            end
            if (st_count < exp_stores.size()) begin
                exp_s = exp_stores[st_count];
                assert (daddr == exp_s.addr && ddata_w == exp_s.data) else begin
                    $display("error store[%0d]: expected [%h] = %h, actual [%h] = %h",
                             st_count, exp_s.addr, exp_s.data, daddr, ddata_w);
                    st_errors++;
                end
            end
            st_count++;
        end
    end

    initial begin
        int cycles;
        void'($urandom(SEED));
        build_program();
        run_reference();
        $display("expecting %0d register writes and %0d stores",
                 exp_writes.size(), exp_stores.size());
        cycles = 0;
        while (!RESET_N && cycles < TIMEOUT) begin
            @(posedge CLK);
            cycles++;
        end
        if (!RESET_N) begin
            $display("timeout: reset was never released");
            other_errors++;
        end else begin
            cycles = 0;
            while ((wr_count < exp_writes.size() || st_count < exp_stores.size())
                   && cycles < TIMEOUT) begin
                @(posedge CLK);
                cycles++;
            end
            if (wr_count < exp_writes.size() || st_count < exp_stores.size()) begin
                $display("timeout: the program did not finish its writes and stores");
                other_errors++;
            end
            // the final self-loop must stay quiet.
            cycles = 0;
            while (cycles < DRAIN) begin
                @(posedge CLK);
                cycles++;
            end
        end
        $display("register write errors: %0d, store errors: %0d, other errors: %0d",
                 wr_errors, st_errors, other_errors);
        if (wr_errors + st_errors + other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verification/rv_clock_gen.sv ====
`timescale 1ns/1ps

module rv_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic CLK,
    output logic RESET_N
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // reset is released on a rising edge after RESET_CYCLES full cycles.
    initial begin
        RESET_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        RESET_N <= 1'b1;
    end

endmodule

// ==== hdl/rv_pipeline.sv ====
`timescale 1ns/1ps

module rv_pipeline #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    output logic [ADDR_SIZE-1:0] iaddr,
    input  logic [31:0]          idata,
    output logic [ADDR_SIZE-1:0] daddr,
    input  logic [31:0]          ddata_r,
    output logic [31:0]          ddata_w,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 reg_write_enable,
    output logic [4:0]           write_register,
    output logic [31:0]          reg_write_data
);

    logic [ADDR_SIZE+1:0] pc;
    logic [ADDR_SIZE+1:0] pc_plus4;
    logic [ADDR_SIZE+1:0] if_id_pc;
    logic [31:0]          if_id_inst;

    rv_pkg::ctrl_t        id_ctrl;
    logic [4:0]           id_rd;
    logic [4:0]           id_rs1;
    logic [4:0]           id_rs2;
    logic                 id_uses_rs1;
    logic                 id_uses_rs2;
    logic [31:0]          id_imm;
    logic [31:0]          id_rs1_data;
    logic [31:0]          id_rs2_data;

    rv_pkg::id_ex_t       id_ex_d;
    rv_pkg::id_ex_t       id_ex;
    rv_pkg::ex_mem_t      ex_mem_d;
    rv_pkg::ex_mem_t      ex_mem;
    rv_pkg::mem_wb_t      mem_wb_d;
    rv_pkg::mem_wb_t      mem_wb;

    logic                 stall;
    logic                 flush;
    logic [ADDR_SIZE+1:0] target;
    logic [31:0]          alu_b;
    logic [31:0]          alu_result;
    logic                 alu_zero;

    // =========================================================================
    // fetch
    // =========================================================================

    assign pc_plus4 = pc + (ADDR_SIZE+2)'(4);
    assign iaddr    = pc[ADDR_SIZE+1:2];

    // a redirect from execute wins over a decode stall.
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc         <= '0;
            if_id_pc   <= '0;
            if_id_inst <= rv_pkg::NOP_WORD;
        end else if (flush) begin
            pc         <= target;
            if_id_inst <= rv_pkg::NOP_WORD;
        end else if (!stall) begin
            pc         <= pc_plus4;
            if_id_pc   <= pc;
            if_id_inst <= idata;
        end
    end

    // =========================================================================
    // decode
    // =========================================================================

    rv_decoder decoder (
        .inst      (if_id_inst),
        .ctrl      (id_ctrl),
        .rd        (id_rd),
        .rs1       (id_rs1),
        .rs2       (id_rs2),
        .uses_rs1  (id_uses_rs1),
        .uses_rs2  (id_uses_rs2),
        .immediate (id_imm)
    );

    rv_regfile regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data),
        .wb       (mem_wb)
    );

    rv_hazard_unit hazard_unit (
        .rs1       (id_rs1),
        .rs2       (id_rs2),
        .uses_rs1  (id_uses_rs1),
        .uses_rs2  (id_uses_rs2),
        .ex_stage  (id_ex),
        .mem_stage (ex_mem),
        .stall     (stall)
    );

    // unused source fields are cleared so the indices carried on name real operands only.
    always_comb begin
        id_ex_d.ctrl      = id_ctrl;
        id_ex_d.pc        = rv_pkg::pc_t'(if_id_pc);
        id_ex_d.rs1_data  = id_rs1_data;
        id_ex_d.rs2_data  = id_rs2_data;
        id_ex_d.immediate = id_imm;
        id_ex_d.rd        = id_rd;
        id_ex_d.rs1       = id_uses_rs1 ? id_rs1 : 5'd0;
        id_ex_d.rs2       = id_uses_rs2 ? id_rs2 : 5'd0;
    end

    // =========================================================================
    // execute
    // =========================================================================

    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.immediate : id_ex.rs2_data;

    rv_alu alu (
        .a      (id_ex.rs1_data),
        .b      (alu_b),
        .op     (id_ex.ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    rv_branch_unit #(
        .ADDR_SIZE (ADDR_SIZE)
    ) branch_unit (
        .ex_stage (id_ex),
        .zero     (alu_zero),
        .flush    (flush),
        .target   (target)
    );

    always_comb begin
        ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = id_ex.rs2_data;
        ex_mem_d.rd         = id_ex.rd;
    end

    // =========================================================================
    // memory and write-back
    // =========================================================================

    assign daddr     = ex_mem.alu_result[ADDR_SIZE+1:2];
    assign ddata_w   = ex_mem.store_data;
    assign mem_read  = ex_mem.mem_read;
    assign mem_write = ex_mem.mem_write;

    always_comb begin
        mem_wb_d.reg_write  = ex_mem.reg_write;
        mem_wb_d.rd         = ex_mem.rd;
        mem_wb_d.write_data = ex_mem.mem_read ? ddata_r : ex_mem.alu_result;
    end

    assign reg_write_enable = mem_wb.reg_write;
    assign write_register   = mem_wb.rd;
    assign reg_write_data   = mem_wb.write_data;

    // a stall or a flush sends a bubble into execute.
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            id_ex  <= (flush || stall) ? '0 : id_ex_d;
            ex_mem <= ex_mem_d;
            mem_wb <= mem_wb_d;
        end
    end

    a_mem_exclusive: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    a_stall_bounded: assert property (@(posedge CLK) disable iff (!RESET_N)
        stall && $past(stall) |=> !stall)
        else $error("decode stalled for more than two cycles");

    a_target_aligned: assert property (@(posedge CLK) disable iff (!RESET_N)
        flush |-> target[1:0] == 2'b00)
        else $error("branch target is not word aligned");

    // the interlock must keep a consumer in decode until its producer leaves memory.
    a_no_raw_in_ex: assert property (@(posedge CLK) disable iff (!RESET_N)
        ex_mem.reg_write |-> (id_ex.rs1 == 5'd0 || id_ex.rs1 != ex_mem.rd) &&
                             (id_ex.rs2 == 5'd0 || id_ex.rs2 != ex_mem.rd))
        else $error("operand in execute depends on the instruction in memory");

endmodule

// ==== hdl/rv_branch_unit.sv ====
`timescale 1ns/1ps

module rv_branch_unit #(
    parameter int ADDR_SIZE = 10
) (
    input  rv_pkg::id_ex_t       ex_stage,
    input  logic                 zero,
    output logic                 flush,
    output logic [ADDR_SIZE+1:0] target
);

    logic taken;

    // fetch goes on sequentially, so only a taken branch needs a redirect.
    assign taken = ex_stage.ctrl.branch_ne ? !zero : zero;
    assign flush = ex_stage.ctrl.branch && taken;

    // the offset is relative to the branch itself, which is the instruction in execute.
    assign target = (ADDR_SIZE+2)'(ex_stage.pc) + (ADDR_SIZE+2)'(ex_stage.immediate);

endmodule

// ==== hdl/rv_hazard_unit.sv ====
`timescale 1ns/1ps

module rv_hazard_unit (
    input  logic            [4:0] rs1,
    input  logic            [4:0] rs2,
    input  logic                  uses_rs1,
    input  logic                  uses_rs2,
    input  rv_pkg::id_ex_t        ex_stage,
    input  rv_pkg::ex_mem_t       mem_stage,
    output logic                  stall
);

    // a source is pending while an older instruction in execute or memory will write it.
    // write-back is covered by the register file bypass.
    function automatic logic pending(input logic [4:0] idx);
        logic ex_hit;
        logic mem_hit;
        ex_hit  = ex_stage.ctrl.reg_write && ex_stage.rd == idx;
        mem_hit = mem_stage.reg_write && mem_stage.rd == idx;
        return idx != 5'd0 && (ex_hit || mem_hit);
    endfunction

    always_comb begin
        stall = (uses_rs1 && pending(rs1)) || (uses_rs2 && pending(rs2));
    end

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic            CLK,
    input  logic            RESET_N,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [31:0]     rs1_data,
    output logic [31:0]     rs2_data,
    input  rv_pkg::mem_wb_t wb
);

    logic [31:0] regs [1:31];
    logic        wr_en;

    assign wr_en = wb.reg_write && wb.rd != 5'd0;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.write_data;
        end
    end

    // a write in progress is returned at once, so decode never sees a stale value.
    function automatic logic [31:0] read_port(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (wr_en && wb.rd == idx) begin
            return wb.write_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    a_x0_zero: assert property (@(posedge CLK) disable iff (!RESET_N)
        (rs1 != 5'd0 || rs1_data == '0) && (rs2 != 5'd0 || rs2_data == '0))
        else $error("x0 read returned a nonzero value");

endmodule

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  rv_pkg::alu_op_e op,
    output logic [31:0]     result,
    output logic            zero
);

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: result = a + b;
            rv_pkg::ALU_SUB: result = a - b;
            rv_pkg::ALU_AND: result = a & b;
            rv_pkg::ALU_OR:  result = a | b;
            rv_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            default:         result = '0;
        endcase
    end

    // branches compare through SUB, so zero means the operands are equal.
    assign zero = result == 32'd0;

endmodule

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
    input  logic [31:0]   inst,
    output rv_pkg::ctrl_t ctrl,
    output logic [4:0]    rd,
    output logic [4:0]    rs1,
    output logic [4:0]    rs2,
    output logic          uses_rs1,
    output logic          uses_rs2,
    output logic [31:0]   immediate
);

    logic [2:0]      funct3;
    logic            arith_ok;
    rv_pkg::alu_op_e arith_op;

    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct3 = inst[14:12];

    // funct3 picks the operation for both the register and the immediate form.
    always_comb begin
        arith_ok = 1'b1;
        arith_op = rv_pkg::ALU_ADD;
        case (funct3)
            3'b000: begin
                if (inst[30] && inst[6:0] == rv_pkg::OP) begin
                    arith_op = rv_pkg::ALU_SUB;
                end
            end
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            3'b111:  arith_op = rv_pkg::ALU_AND;
            default: arith_ok = 1'b0;
        endcase
    end

    always_comb begin
        ctrl      = '0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        immediate = {{20{inst[31]}}, inst[31:20]};
        case (rv_pkg::opcode_e'(inst[6:0]))
            rv_pkg::OP: begin
                if (arith_ok) begin
                    ctrl.reg_write = rd != 5'd0;
                    ctrl.alu_op    = arith_op;
                    uses_rs1       = 1'b1;
                    uses_rs2       = 1'b1;
                end
            end
            rv_pkg::OP_IMM: begin
                if (arith_ok) begin
                    ctrl.reg_write   = rd != 5'd0;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = arith_op;
                    uses_rs1         = 1'b1;
                end
            end
            rv_pkg::LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.reg_write   = rd != 5'd0;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    uses_rs1         = 1'b1;
                end
            end
            rv_pkg::STORE: begin
                immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                if (funct3 == 3'b010) begin
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    uses_rs1         = 1'b1;
                    uses_rs2         = 1'b1;
                end
            end
            rv_pkg::BRANCH: begin
                immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                if (funct3[2:1] == 2'b00) begin
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    ctrl.alu_op    = rv_pkg::ALU_SUB;
                    uses_rs1       = 1'b1;
                    uses_rs2       = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    // major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    typedef logic [11:0] pc_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    branch;
        logic    branch_ne;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        pc_t         pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] immediate;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
    } id_ex_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] write_data;
    } mem_wb_t;

    // addi x0, x0, 0.
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

endpackage
